// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

////////////////////
// Core sizing
////////////////////

// Register and data path width
`define RV_XLEN 32

// Instruction ROM depth in words, PC wraps at this size
`define RV_IMEM_WORDS 64

// Data RAM depth in words, addresses wrap at this size
`define RV_DMEM_WORDS 64

`endif

// ==== rtl/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opOpImm  = 7'b0010011,
    opOp     = 7'b0110011
  } opcodeE;

  // Branch conditions in funct3
  typedef enum logic [2:0] {
    f3Beq  = 3'b000,
    f3Bne  = 3'b001,
    f3Blt  = 3'b100,
    f3Bge  = 3'b101,
    f3Bltu = 3'b110,
    f3Bgeu = 3'b111
  } branchF3E;

  // Load and store widths in funct3
  typedef enum logic [2:0] {
    memByte  = 3'b000,
    memHalf  = 3'b001,
    memWord  = 3'b010,
    memByteU = 3'b100,
    memHalfU = 3'b101
  } memF3E;

  // ALU groups in funct3 for OP and OP-IMM
  typedef enum logic [2:0] {
    f3AddSub = 3'b000,
    f3Sll    = 3'b001,
    f3Slt    = 3'b010,
    f3Sltu   = 3'b011,
    f3Xor    = 3'b100,
    f3Srl    = 3'b101,
    f3Or     = 3'b110,
    f3And    = 3'b111
  } aluF3E;

endpackage

`default_nettype wire

// ==== rtl/rvCtrlPkg.sv ====
`default_nettype none

package rvCtrlPkg;

  // ALU function select
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB
  } aluOpE;

  // Source of ALU operand A
  typedef enum logic [1:0] {
    aRs1,
    aPc,
    aZero
  } aSelE;

  // Immediate layout in the instruction word
  typedef enum logic [2:0] {
    immI,
    immS,
    immB,
    immU,
    immJ
  } immFmtE;

  // Register writeback source
  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbPcPlus4
  } wbSelE;

endpackage

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

`include "rv_macros.svh"

module alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rvCtrlPkg::aluOpE    aluOp,
  output logic [`RV_XLEN-1:0] result,
  output logic                zero,
  output logic                lt,
  output logic                ltu
);

  logic [4:0] shamt;

  // Only low five bits shift
  assign shamt = b[4:0];

  // Compare flags, independent of the operation
  assign zero = (a == b);
  assign lt   = $signed(a) < $signed(b);
  assign ltu  = a < b;

  ////////////////////
  // Function select
  ////////////////////
  always_comb begin
    case (aluOp)
      rvCtrlPkg::aluAdd:   result = a + b;
      rvCtrlPkg::aluSub:   result = a - b;
      rvCtrlPkg::aluSll:   result = a << shamt;
      // Set-less-than reuses the flags
      rvCtrlPkg::aluSlt:   result = {{(`RV_XLEN - 1){1'b0}}, lt};
      rvCtrlPkg::aluSltu:  result = {{(`RV_XLEN - 1){1'b0}}, ltu};
      rvCtrlPkg::aluXor:   result = a ^ b;
      rvCtrlPkg::aluSrl:   result = a >> shamt;
      rvCtrlPkg::aluSra:   result = $unsigned($signed(a) >>> shamt);
      rvCtrlPkg::aluOr:    result = a | b;
      rvCtrlPkg::aluAnd:   result = a & b;
      // LUI path
      rvCtrlPkg::aluPassB: result = b;
      default:             result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/immGen.sv ====
`default_nettype none

`include "rv_macros.svh"

module immGen (
  input  logic [`RV_XLEN-1:0] instr,
  input  rvCtrlPkg::immFmtE   immFmt,
  output logic [`RV_XLEN-1:0] imm
);

  logic sign;

  assign sign = instr[31];

  always_comb begin
    case (immFmt)
      rvCtrlPkg::immS: begin
        imm = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      rvCtrlPkg::immB: begin
        // Halfword offset, bit 0 implied
        imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rvCtrlPkg::immU: begin
        imm = {instr[31:12], 12'b0};
      end
      rvCtrlPkg::immJ: begin
        imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        // I format, shifts use only the low five bits in the ALU
        imm = {{20{sign}}, instr[31:20]};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

`include "rv_macros.svh"

module regFile (
  input  logic                clk,
  input  logic                arstN,
  input  logic                we,
  input  logic [4:0]          rs1Addr,
  input  logic [4:0]          rs2Addr,
  input  logic [4:0]          rdAddr,
  input  logic [`RV_XLEN-1:0] rdData,
  output logic [`RV_XLEN-1:0] rs1Data,
  output logic [`RV_XLEN-1:0] rs2Data
);

  // x1..x31, x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:31];

  // Write port, rd 0 already filtered by the decoder
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rdAddr] <= rdData;
    end
  end

  // Read ports, old value on same-cycle write
  assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
  assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== rtl/dataMem.sv ====
`default_nettype none

`include "rv_macros.svh"

module dataMem #(
  localparam int DmemAw = $clog2(`RV_DMEM_WORDS)
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                we,
  input  rvIsaPkg::memF3E     f3,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] storeData,
  output logic [`RV_XLEN-1:0] loadData
);

  logic [`RV_XLEN-1:0] ram [`RV_DMEM_WORDS];
  logic [DmemAw-1:0]   wordIdx;
  logic [1:0]          byteOff;
  logic [3:0]          byteEn;
  logic [`RV_XLEN-1:0] laneData;
  logic [`RV_XLEN-1:0] rdWord;
  logic [7:0]          rdByte;
  logic [15:0]         rdHalf;

  // Word index wraps at RAM size
  assign wordIdx = addr[DmemAw+1:2];
  assign byteOff = addr[1:0];

  ////////////////////
  // Store lanes
  ////////////////////
  always_comb begin
    case (f3)
      rvIsaPkg::memByte: begin
        byteEn   = 4'b0001 << byteOff;
        laneData = {4{storeData[7:0]}};
      end
      rvIsaPkg::memHalf: begin
        // Halfword lane from bit 1
        byteEn   = 4'b0011 << {byteOff[1], 1'b0};
        laneData = {2{storeData[15:0]}};
      end
      default: begin
        byteEn   = 4'b1111;
        laneData = storeData;
      end
    endcase
  end

  // Cleared on reset, byte-enabled write
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
        ram[i] <= '0;
      end
    end else if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (byteEn[b]) begin
          ram[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // Load extract
  ////////////////////
  assign rdWord = ram[wordIdx];
  assign rdByte = rdWord[8*byteOff +: 8];
  assign rdHalf = rdWord[16*byteOff[1] +: 16];

  always_comb begin
    case (f3)
      rvIsaPkg::memByte:  loadData = {{24{rdByte[7]}}, rdByte};
      rvIsaPkg::memHalf:  loadData = {{16{rdHalf[15]}}, rdHalf};
      rvIsaPkg::memByteU: loadData = {24'b0, rdByte};
      rvIsaPkg::memHalfU: loadData = {16'b0, rdHalf};
      default:            loadData = rdWord;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/instrFetch.sv ====
`default_nettype none

`include "rv_macros.svh"

module instrFetch #(
  localparam int ImemAw = $clog2(`RV_IMEM_WORDS)
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                progWe,
  input  logic [ImemAw-1:0]   progAddr,
  input  logic [`RV_XLEN-1:0] progData,
  input  logic                pcSel,
  input  logic                jalrTarget,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] aluResult,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pcPlus4,
  output logic [`RV_XLEN-1:0] instr
);

  logic [`RV_XLEN-1:0] rom [`RV_IMEM_WORDS];
  logic [ImemAw-1:0]   pcIdx;
  logic [`RV_XLEN-1:0] pcTarget;
  logic [`RV_XLEN-1:0] nextPc;

  // Program load port, ROM keeps its contents over reset
  always_ff @(posedge clk) begin
    if (progWe) begin
      rom[progAddr] <= progData;
    end
  end

  // Word index only, so pc stays aligned and wraps at ROM size
  assign pc       = {{(`RV_XLEN - ImemAw - 2){1'b0}}, pcIdx, 2'b00};
  assign pcPlus4  = pc + `RV_XLEN'd4;
  assign pcTarget = pc + imm;
  assign instr    = rom[pcIdx];

  // JALR clears bit 0 of rs1 + imm
  always_comb begin
    if (!pcSel) begin
      nextPc = pcPlus4;
    end else if (jalrTarget) begin
      nextPc = {aluResult[`RV_XLEN-1:1], 1'b0};
    end else begin
      nextPc = pcTarget;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcIdx <= '0;
    end else begin
      pcIdx <= nextPc[ImemAw+1:2];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/controlUnit.sv ====
`default_nettype none

`include "rv_macros.svh"

module controlUnit (
  input  logic                arstN,
  input  logic [`RV_XLEN-1:0] instr,
  input  logic                zero,
  input  logic                lt,
  input  logic                ltu,
  output rvCtrlPkg::aluOpE    aluOp,
  output rvCtrlPkg::aSelE     aSel,
  output logic                bSelImm,
  output rvCtrlPkg::immFmtE   immFmt,
  output logic                memWe,
  output rvIsaPkg::memF3E     memF3,
  output rvCtrlPkg::wbSelE    wbSel,
  output logic                regWe,
  output logic                pcSel,
  output logic                jalrTarget
);

  rvIsaPkg::opcodeE opcode;
  logic [2:0]       funct3;
  logic             funct7b5;
  logic [4:0]       rd;
  logic             regWeRaw;
  logic             memWeRaw;
  logic             isBranch;
  logic             isJump;
  logic             taken;
  rvCtrlPkg::aluOpE aluFn;

  // Instruction fields
  assign opcode   = rvIsaPkg::opcodeE'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];
  assign rd       = instr[11:7];
  assign memF3    = rvIsaPkg::memF3E'(funct3);

  ////////////////////
  // ALU function from funct3/funct7
  ////////////////////
  always_comb begin
    case (rvIsaPkg::aluF3E'(funct3))
      // SUB only exists in register form
      rvIsaPkg::f3AddSub: begin
        aluFn = (opcode == rvIsaPkg::opOp && funct7b5) ? rvCtrlPkg::aluSub : rvCtrlPkg::aluAdd;
      end
      rvIsaPkg::f3Sll:  aluFn = rvCtrlPkg::aluSll;
      rvIsaPkg::f3Slt:  aluFn = rvCtrlPkg::aluSlt;
      rvIsaPkg::f3Sltu: aluFn = rvCtrlPkg::aluSltu;
      rvIsaPkg::f3Xor:  aluFn = rvCtrlPkg::aluXor;
      // Arithmetic shift in both forms
      rvIsaPkg::f3Srl:  aluFn = funct7b5 ? rvCtrlPkg::aluSra : rvCtrlPkg::aluSrl;
      rvIsaPkg::f3Or:   aluFn = rvCtrlPkg::aluOr;
      default:          aluFn = rvCtrlPkg::aluAnd;
    endcase
  end

  ////////////////////
  // Main decode
  ////////////////////
  always_comb begin
    // No-op defaults, also used for undefined opcodes
    aluOp    = rvCtrlPkg::aluAdd;
    aSel     = rvCtrlPkg::aRs1;
    bSelImm  = 1'b0;
    immFmt   = rvCtrlPkg::immI;
    wbSel    = rvCtrlPkg::wbAlu;
    regWeRaw = 1'b0;
    memWeRaw = 1'b0;
    isBranch = 1'b0;
    isJump   = 1'b0;
    jalrTarget = 1'b0;
    case (opcode)
      rvIsaPkg::opLui: begin
        // 0 + imm through passB
        aSel     = rvCtrlPkg::aZero;
        aluOp    = rvCtrlPkg::aluPassB;
        bSelImm  = 1'b1;
        immFmt   = rvCtrlPkg::immU;
        regWeRaw = 1'b1;
      end
      rvIsaPkg::opAuipc: begin
        aSel     = rvCtrlPkg::aPc;
        bSelImm  = 1'b1;
        immFmt   = rvCtrlPkg::immU;
        regWeRaw = 1'b1;
      end
      rvIsaPkg::opJal: begin
        aSel     = rvCtrlPkg::aPc;
        bSelImm  = 1'b1;
        immFmt   = rvCtrlPkg::immJ;
        wbSel    = rvCtrlPkg::wbPcPlus4;
        regWeRaw = 1'b1;
        isJump   = 1'b1;
      end
      rvIsaPkg::opJalr: begin
        // Target is rs1 + imm out of the ALU
        bSelImm    = 1'b1;
        wbSel      = rvCtrlPkg::wbPcPlus4;
        regWeRaw   = 1'b1;
        isJump     = 1'b1;
        jalrTarget = 1'b1;
      end
      rvIsaPkg::opBranch: begin
        // ALU compares rs1 with rs2, target from the fetch adder
        aluOp    = rvCtrlPkg::aluSub;
        immFmt   = rvCtrlPkg::immB;
        isBranch = 1'b1;
      end
      rvIsaPkg::opLoad: begin
        bSelImm  = 1'b1;
        wbSel    = rvCtrlPkg::wbMem;
        regWeRaw = 1'b1;
      end
      rvIsaPkg::opStore: begin
        bSelImm  = 1'b1;
        immFmt   = rvCtrlPkg::immS;
        memWeRaw = 1'b1;
      end
      rvIsaPkg::opOpImm: begin
        aluOp    = aluFn;
        bSelImm  = 1'b1;
        regWeRaw = 1'b1;
      end
      rvIsaPkg::opOp: begin
        aluOp    = aluFn;
        regWeRaw = 1'b1;
      end
      default: begin
      end
    endcase
  end

  ////////////////////
  // Branch decision
  ////////////////////
  always_comb begin
    case (rvIsaPkg::branchF3E'(funct3))
      rvIsaPkg::f3Beq:  taken = zero;
      rvIsaPkg::f3Bne:  taken = !zero;
      rvIsaPkg::f3Blt:  taken = lt;
      rvIsaPkg::f3Bge:  taken = !lt;
      rvIsaPkg::f3Bltu: taken = ltu;
      rvIsaPkg::f3Bgeu: taken = !ltu;
      default:          taken = 1'b0;
    endcase
  end

  assign pcSel = isJump || (isBranch && taken);

  // No writes to x0 and none while reset is held
  assign regWe = regWeRaw && (rd != 5'd0) && arstN;
  assign memWe = memWeRaw && arstN;

endmodule

`default_nettype wire

// ==== rtl/rvCore.sv ====
`default_nettype none

`include "rv_macros.svh"

module rvCore #(
  localparam int ImemAw = $clog2(`RV_IMEM_WORDS)
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                progWe,
  input  logic [ImemAw-1:0]   progAddr,
  input  logic [`RV_XLEN-1:0] progData,
  output logic [`RV_XLEN-1:0] pc,
  output logic                wbEn,
  output logic [4:0]          wbAddr,
  output logic [`RV_XLEN-1:0] wbData
);

  logic [`RV_XLEN-1:0] pcPlus4;
  logic [`RV_XLEN-1:0] instr;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rs1Data;
  logic [`RV_XLEN-1:0] rs2Data;
  logic [`RV_XLEN-1:0] aluA;
  logic [`RV_XLEN-1:0] aluB;
  logic [`RV_XLEN-1:0] aluResult;
  logic [`RV_XLEN-1:0] loadData;
  logic                zero;
  logic                lt;
  logic                ltu;
  rvCtrlPkg::aluOpE    aluOp;
  rvCtrlPkg::aSelE     aSel;
  logic                bSelImm;
  rvCtrlPkg::immFmtE   immFmt;
  logic                memWe;
  rvIsaPkg::memF3E     memF3;
  rvCtrlPkg::wbSelE    wbSel;
  logic                regWe;
  logic                pcSel;
  logic                jalrTarget;

  ////////////////////
  // Fetch and decode
  ////////////////////
  instrFetch uFetch (
    .clk, .arstN, .progWe, .progAddr, .progData, .pcSel, .jalrTarget,
    .imm, .aluResult, .pc, .pcPlus4, .instr
  );

  controlUnit uCtrl (
    .arstN, .instr, .zero, .lt, .ltu, .aluOp, .aSel, .bSelImm, .immFmt,
    .memWe, .memF3, .wbSel, .regWe, .pcSel, .jalrTarget
  );

  immGen uImm (.instr, .immFmt, .imm);

  regFile uRegs (
    .clk, .arstN, .we(regWe), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
    .rdAddr(instr[11:7]), .rdData(wbData), .rs1Data, .rs2Data
  );

  ////////////////////
  // Execute and memory
  ////////////////////
  // Operand A from rs1, pc or zero
  always_comb begin
    case (aSel)
      rvCtrlPkg::aPc:   aluA = pc;
      rvCtrlPkg::aZero: aluA = '0;
      default:          aluA = rs1Data;
    endcase
  end

  assign aluB = bSelImm ? imm : rs2Data;

  alu uAlu (.a(aluA), .b(aluB), .aluOp, .result(aluResult), .zero, .lt, .ltu);

  // Store data straight from rs2
  dataMem uDmem (
    .clk, .arstN, .we(memWe), .f3(memF3), .addr(aluResult), .storeData(rs2Data),
    .loadData
  );

  // Writeback select
  always_comb begin
    case (wbSel)
      rvCtrlPkg::wbMem:     wbData = loadData;
      rvCtrlPkg::wbPcPlus4: wbData = pcPlus4;
      default:              wbData = aluResult;
    endcase
  end

  assign wbEn   = regWe;
  assign wbAddr = instr[11:7];

endmodule

`default_nettype wire

// ==== tb/rvCore_properties.sv ====
`default_nettype none

`include "rv_macros.svh"

module rvCore_properties (
  input logic                clk,
  input logic                arstN,
  input logic [`RV_XLEN-1:0] pc,
  input logic                wbEn,
  input logic [4:0]          wbAddr
);

  ////////////////////
  // Fetch
  ////////////////////
  // Word aligned fetch at all times
  pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

  ////////////////////
  // Writeback
  ////////////////////
  // Decoder drops writes to x0
  noWriteX0: assert property (@(posedge clk) disable iff (!arstN) !(wbEn && wbAddr == 5'd0))
    else $error("writeback strobe with rd x0");

  // Strobe gated by the reset level
  quietInReset: assert property (@(posedge clk) !arstN |-> !wbEn)
    else $error("writeback strobe while reset is held");

endmodule

`default_nettype wire

// ==== tb/rvCore_tb.sv ====
`default_nettype none

`include "rv_macros.svh"

module rvCore_tb;

  localparam int ImemWords    = `RV_IMEM_WORDS;
  localparam int ImemAw       = $clog2(`RV_IMEM_WORDS);
  localparam int ByteAw       = $clog2(4 * `RV_DMEM_WORDS);
  localparam int NumProgs     = 4;
  localparam int ResetCycles  = 5;
  localparam int StepsPerProg = 400;
  // Load, reset and run per program, plus some slack
  localparam int CycleLimit   = NumProgs * (ImemWords + 1 + ResetCycles + StepsPerProg) + 100;

  // Instruction classes for the generator
  localparam int kOp     = 0;
  localparam int kOpImm  = 1;
  localparam int kLoad   = 2;
  localparam int kStore  = 3;
  localparam int kBranch = 4;
  localparam int kJal    = 5;
  localparam int kJalr   = 6;
  localparam int kLui    = 7;
  localparam int kAuipc  = 8;

  logic                clk;
  logic                arstN;
  logic                progWe;
  logic [ImemAw-1:0]   progAddr;
  logic [`RV_XLEN-1:0] progData;
  logic [`RV_XLEN-1:0] pc;
  logic                wbEn;
  logic [4:0]          wbAddr;
  logic [`RV_XLEN-1:0] wbData;

  // Program image and ISA model state
  logic [31:0] progRom [ImemWords];
  logic [31:0] mRegs [32];
  logic [7:0]  mMem [4 * `RV_DMEM_WORDS];
  logic [31:0] mPc;
  logic        expEn;
  logic [4:0]  expAddr;
  logic [31:0] expData;

  logic [31:0] lcgState;
  string       testName;
  int          checks;
  int          errPc;
  int          errEn;
  int          errAddr;
  int          errData;
  int          errReset;
  int          cycles = 0;

  rvCore dut (
    .clk, .arstN, .progWe, .progAddr, .progData, .pc, .wbEn, .wbAddr, .wbData
  );

  bind rvCore rvCore_properties uProps (
    .clk(clk), .arstN(arstN), .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Random source
  ////////////////////
  // Upper bits only, low LCG bits cycle too fast
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return {8'h00, lcgState[31:8]};
  endfunction

  ////////////////////
  // Instruction encoders
  ////////////////////
  function automatic logic [31:0] rTypeWord(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                            logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rvIsaPkg::opOp};
  endfunction

  function automatic logic [31:0] iTypeWord(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                            logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] storeWord(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                            logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rvIsaPkg::opStore};
  endfunction

  // Offset in bytes, bit 0 dropped
  function automatic logic [31:0] branchWord(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvIsaPkg::opBranch};
  endfunction

  function automatic logic [31:0] upperWord(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jalWord(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::opJal};
  endfunction

  ////////////////////
  // Program generator
  ////////////////////
  // Instruction mix, r in 0..15
  function automatic int pickKind(int prog, int r);
    case (prog)
      0: begin
        if (r < 7) return kOp;
        if (r < 13) return kOpImm;
        if (r < 15) return kLui;
        return kAuipc;
      end
      1: begin
        if (r < 4) return kOp;
        if (r < 6) return kOpImm;
        if (r < 10) return kLoad;
        if (r < 15) return kStore;
        return kLui;
      end
      2: begin
        if (r < 4) return kOp;
        if (r < 6) return kOpImm;
        if (r < 11) return kBranch;
        if (r < 13) return kJal;
        if (r < 15) return kJalr;
        return kLui;
      end
      default: begin
        if (r < 2) return kOp;
        if (r < 4) return kOpImm;
        if (r < 6) return kLoad;
        if (r < 8) return kStore;
        if (r < 9) return kBranch;
        if (r < 10) return kJal;
        if (r < 11) return kJalr;
        if (r < 13) return kLui;
        return kAuipc;
      end
    endcase
  endfunction

  function automatic string progName(int prog);
    case (prog)
      0: return "aluOps";
      1: return "loadStore";
      2: return "controlFlow";
      default: return "upperMixed";
    endcase
  endfunction

  function automatic logic [31:0] makeInstr(int prog, int idx);
    int                kind;
    int                target;
    int                sel;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        shamt;
    logic [2:0]        f3;
    logic              alt;
    logic [11:0]       imm12;
    logic [ByteAw-1:0] addr;
    logic [31:0]       ins;
    kind  = pickKind(prog, int'(nextRandom() % 32'd16));
    // Eight registers so results feed later instructions
    rd    = 5'(nextRandom() % 32'd8);
    rs1   = 5'(nextRandom() % 32'd8);
    rs2   = 5'(nextRandom() % 32'd8);
    f3    = 3'(nextRandom() % 32'd8);
    shamt = 5'(nextRandom() % 32'd32);
    alt   = (nextRandom() % 32'd2) == 32'd1;
    // Narrow window gives lane overlap across widths
    addr  = (prog == 1) ? ByteAw'(nextRandom() % 32'd32) : ByteAw'(nextRandom());
    // Last word has nowhere forward to go
    if (idx == ImemWords - 1 && kind >= kBranch && kind <= kJalr) begin
      kind = kOpImm;
    end
    // Forward targets only, no endless loops
    if (idx < ImemWords - 1) begin
      target = idx + 1 + int'(nextRandom() % 32'(ImemWords - 1 - idx));
    end else begin
      target = idx;
    end
    case (kind)
      kOp: begin
        alt = alt && (f3 == rvIsaPkg::f3AddSub || f3 == rvIsaPkg::f3Srl);
        ins = rTypeWord(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd);
      end
      kOpImm: begin
        if (f3 == rvIsaPkg::f3Sll) begin
          imm12 = {7'b0000000, shamt};
        end else if (f3 == rvIsaPkg::f3Srl) begin
          imm12 = {alt ? 7'b0100000 : 7'b0000000, shamt};
        end else begin
          imm12 = 12'(nextRandom());
        end
        ins = iTypeWord(imm12, rs1, f3, rd, rvIsaPkg::opOpImm);
      end
      kLoad: begin
        // Widths 0, 1, 2, 4, 5
        sel = int'(nextRandom() % 32'd5);
        f3  = (sel < 3) ? 3'(sel) : 3'(sel + 1);
        if (f3[1:0] == 2'd1) begin
          addr[0] = 1'b0;
        end else if (f3[1:0] == 2'd2) begin
          addr[1:0] = 2'b00;
        end
        ins = iTypeWord(12'(addr), 5'd0, f3, rd, rvIsaPkg::opLoad);
      end
      kStore: begin
        f3 = 3'(nextRandom() % 32'd3);
        if (f3 == 3'd1) begin
          addr[0] = 1'b0;
        end else if (f3 == 3'd2) begin
          addr[1:0] = 2'b00;
        end
        ins = storeWord(12'(addr), rs2, 5'd0, f3);
      end
      kBranch: begin
        // Skip the two reserved codes
        sel = int'(nextRandom() % 32'd6);
        f3  = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        ins = branchWord(13'((target - idx) * 4), rs2, rs1, f3);
      end
      kJal: ins = jalWord(21'((target - idx) * 4), rd);
      // Absolute target off x0, bit 0 sometimes set
      kJalr: ins = iTypeWord(12'(target * 4 + int'(alt)), 5'd0, 3'd0, rd, rvIsaPkg::opJalr);
      kLui: ins = upperWord(20'(nextRandom()), rd, rvIsaPkg::opLui);
      default: ins = upperWord(20'(nextRandom()), rd, rvIsaPkg::opAuipc);
    endcase
    return ins;
  endfunction

  ////////////////////
  // ISA model
  ////////////////////
  function automatic logic [31:0] aluValue(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
    case (f3)
      rvIsaPkg::f3AddSub: return alt ? a - b : a + b;
      rvIsaPkg::f3Sll:    return a << b[4:0];
      rvIsaPkg::f3Slt:    return {31'b0, $signed(a) < $signed(b)};
      rvIsaPkg::f3Sltu:   return {31'b0, a < b};
      rvIsaPkg::f3Xor:    return a ^ b;
      rvIsaPkg::f3Srl:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      rvIsaPkg::f3Or:     return a | b;
      default:            return a & b;
    endcase
  endfunction

  function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      rvIsaPkg::f3Beq:  return a == b;
      rvIsaPkg::f3Bne:  return a != b;
      rvIsaPkg::f3Blt:  return $signed(a) < $signed(b);
      rvIsaPkg::f3Bge:  return $signed(a) >= $signed(b);
      rvIsaPkg::f3Bltu: return a < b;
      default:          return a >= b;
    endcase
  endfunction

  // Little endian byte memory
  function automatic logic [31:0] loadValue(logic [2:0] width, logic [31:0] addr);
    logic [ByteAw-1:0] i;
    logic [31:0]       w;
    i = addr[ByteAw-1:0];
    w = {mMem[i + ByteAw'(3)], mMem[i + ByteAw'(2)], mMem[i + ByteAw'(1)], mMem[i]};
    case (width)
      rvIsaPkg::memByte:  return {{24{w[7]}}, w[7:0]};
      rvIsaPkg::memHalf:  return {{16{w[15]}}, w[15:0]};
      rvIsaPkg::memByteU: return {24'b0, w[7:0]};
      rvIsaPkg::memHalfU: return {16'b0, w[15:0]};
      default:            return w;
    endcase
  endfunction

  task automatic storeValue(logic [2:0] width, logic [31:0] addr, logic [31:0] data);
    logic [ByteAw-1:0] i;
    i = addr[ByteAw-1:0];
    mMem[i] = data[7:0];
    if (width != rvIsaPkg::memByte) begin
      mMem[i + ByteAw'(1)] = data[15:8];
    end
    if (width == rvIsaPkg::memWord) begin
      mMem[i + ByteAw'(2)] = data[23:16];
      mMem[i + ByteAw'(3)] = data[31:24];
    end
  endtask

  task automatic modelReset();
    mPc = 32'd0;
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = 32'd0;
    end
    for (int i = 0; i < 4 * `RV_DMEM_WORDS; i++) begin
      mMem[i] = 8'd0;
    end
  endtask

  // One instruction at mPc, sets the expected writeback
  task automatic modelStep();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] immU;
    logic [31:0] res;
    logic [31:0] next;
    logic [2:0]  f3;
    ins  = progRom[mPc[ImemAw+1:2]];
    f3   = ins[14:12];
    a    = mRegs[ins[19:15]];
    b    = mRegs[ins[24:20]];
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    immU = {ins[31:12], 12'h000};
    next = mPc + 32'd4;
    res  = 32'd0;
    expEn = 1'b1;
    case (ins[6:0])
      rvIsaPkg::opLui:   res = immU;
      rvIsaPkg::opAuipc: res = mPc + immU;
      rvIsaPkg::opJal: begin
        res  = mPc + 32'd4;
        next = mPc + immJ;
      end
      rvIsaPkg::opJalr: begin
        res  = mPc + 32'd4;
        next = (a + immI) & ~32'd1;
      end
      rvIsaPkg::opBranch: begin
        expEn = 1'b0;
        if (branchTaken(f3, a, b)) begin
          next = mPc + immB;
        end
      end
      rvIsaPkg::opLoad: res = loadValue(f3, a + immI);
      rvIsaPkg::opStore: begin
        expEn = 1'b0;
        storeValue(f3, a + immS, b);
      end
      // Shift immediates keep only the shamt field
      rvIsaPkg::opOpImm: begin
        if (f3 == rvIsaPkg::f3Sll || f3 == rvIsaPkg::f3Srl) begin
          res = aluValue(f3, ins[30], a, {27'b0, ins[24:20]});
        end else begin
          res = aluValue(f3, 1'b0, a, immI);
        end
      end
      rvIsaPkg::opOp: res = aluValue(f3, ins[30], a, b);
      default: expEn = 1'b0;
    endcase
    // x0 stays zero and shows no writeback
    if (ins[11:7] == 5'd0) begin
      expEn = 1'b0;
    end
    expAddr = ins[11:7];
    expData = res;
    if (expEn) begin
      mRegs[ins[11:7]] = res;
    end
    mPc = next & 32'(4 * ImemWords - 1);
  endtask

  ////////////////////
  // Checker
  ////////////////////
  task automatic checkStep();
    logic [31:0] expPc;
    expPc = mPc;
    modelStep();
    checks++;
    if (pc !== expPc) begin
      errPc++;
      $display("ERR %s pc expected %h actual %h", testName, expPc, pc);
    end
    if (wbEn !== expEn) begin
      errEn++;
      $display("ERR %s wbEn at pc %h expected %b actual %b", testName, expPc, expEn, wbEn);
    end
    if (expEn && wbAddr !== expAddr) begin
      errAddr++;
      $display("ERR %s wbAddr at pc %h expected %0d actual %0d", testName, expPc, expAddr,
               wbAddr);
    end
    if (expEn && wbData !== expData) begin
      errData++;
      $display("ERR %s wbData at pc %h expected %h actual %h", testName, expPc, expData,
               wbData);
    end
  endtask

  // Core held at pc 0 and silent through reset
  always @(negedge clk) begin
    if (arstN === 1'b0) begin
      checks++;
      if (pc !== 32'd0) begin
        errReset++;
        $display("ERR reset pc expected %h actual %h", 32'd0, pc);
      end
      if (wbEn !== 1'b0) begin
        errReset++;
        $display("ERR reset wbEn expected %b actual %b", 1'b0, wbEn);
      end
    end
  end

  ////////////////////
  // Sequencing
  ////////////////////
  // Load under reset, then run the program against the model
  task automatic runProgram(int prog);
    testName = progName(prog);
    for (int i = 0; i < ImemWords; i++) begin
      progRom[i] = makeInstr(prog, i);
    end
    modelReset();
    for (int i = 0; i < ImemWords; i++) begin
      @(posedge clk);
      arstN    <= 1'b0;
      progWe   <= 1'b1;
      progAddr <= ImemAw'(i);
      progData <= progRom[i];
    end
    @(posedge clk);
    progWe <= 1'b0;
    repeat (ResetCycles) @(posedge clk);
    arstN <= 1'b1;
    repeat (StepsPerProg) begin
      @(negedge clk);
      checkStep();
    end
  endtask

  task automatic printCounts();
    $display("Checks %0d, errors pc %0d wbEn %0d wbAddr %0d wbData %0d reset %0d",
             checks, errPc, errEn, errAddr, errData, errReset);
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Run hit %0d cycles before the programs finished, core or testbench hang",
               cycles);
      printCounts();
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    arstN    = 1'b0;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    lcgState = 32'd78;
    checks   = 0;
    errPc    = 0;
    errEn    = 0;
    errAddr  = 0;
    errData  = 0;
    errReset = 0;
    for (int p = 0; p < NumProgs; p++) begin
      runProgram(p);
    end
    printCounts();
    if (errPc + errEn + errAddr + errData + errReset == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rvCore.f ====
+incdir+include
rtl/rvIsaPkg.sv
rtl/rvCtrlPkg.sv
rtl/alu.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/dataMem.sv
rtl/instrFetch.sv
rtl/controlUnit.sv
rtl/rvCore.sv
tb/rvCore_properties.sv
tb/rvCore_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module rvCore_tb -f rvCore.f

run: compile
	./obj_dir/VrvCore_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
